// ==== vlog.f ====
src/adma_pkg.sv
src/adma_control.sv
src/descriptor_fetch.sv
src/data_transfer.sv
src/adma_top.sv
testbench/adma_mem_model.sv
testbench/adma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the adma testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module adma_tb -f vlog.f -o adma_sim

./obj_dir/adma_sim > sim.log 2>&1 || {
   cat sim.log
   echo "simulation exited with an error status"
   exit 1
}
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
   exit 1
fi
exit 0

// ==== testbench/adma_tb.sv ====
// testbench for the adma engine running directed descriptor chain tests
`timescale 1ns/1ps
`default_nettype none

module adma_tb;

   // under 50 words and 12 descriptors in total, each well below 100 cycles at worst stalls
   localparam int unsigned timeout_cycles = 20000;

   // action codes as {act2, act1}
   localparam logic [1:0] code_nop  = 2'b00;
   localparam logic [1:0] code_tran = 2'b10;
   localparam logic [1:0] code_link = 2'b11;

   logic               CLK;
   logic               RESET;
   logic               start_valid;
   adma_pkg::addr_t    start_addr;
   logic               cont_valid;
   logic               dir;
   logic               stop_req;
   logic               busy;
   logic               done;
   logic               irq;
   logic               error;
   adma_pkg::mem_req_t mem_req;
   logic               mem_req_valid;
   logic               mem_req_ready;
   logic               mem_rsp_valid;
   adma_pkg::word_t    mem_rsp_data;
   adma_pkg::word_t    fifo_in_data;
   logic               fifo_in_valid;
   logic               fifo_in_ready;
   adma_pkg::word_t    fifo_out_data;
   logic               fifo_out_valid;
   logic               fifo_out_ready;
   logic               mem_ready_en;
   logic               sink_throttle;

   adma_pkg::word_t src_q [$];
   adma_pkg::word_t recv_q [$];
   adma_pkg::word_t exp_q [$];
   int unsigned     done_cnt;
   int unsigned     irq_cnt;
   logic            error_seen;
   logic            error_q;
   int unsigned     err_cnt;
   int unsigned     check_cnt;
   int unsigned     test_cnt;
   int unsigned     test_err_base;
   int unsigned     cycle_cnt;

   adma_top #(
      .MAX_OUTSTANDING (2)
   ) dut (
      .CLK            (CLK),
      .RESET          (RESET),
      .start_valid    (start_valid),
      .start_addr     (start_addr),
      .cont_valid     (cont_valid),
      .dir            (dir),
      .stop_req       (stop_req),
      .busy           (busy),
      .done           (done),
      .irq            (irq),
      .error          (error),
      .mem_req        (mem_req),
      .mem_req_valid  (mem_req_valid),
      .mem_req_ready  (mem_req_ready),
      .mem_rsp_valid  (mem_rsp_valid),
      .mem_rsp_data   (mem_rsp_data),
      .fifo_in_data   (fifo_in_data),
      .fifo_in_valid  (fifo_in_valid),
      .fifo_in_ready  (fifo_in_ready),
      .fifo_out_data  (fifo_out_data),
      .fifo_out_valid (fifo_out_valid),
      .fifo_out_ready (fifo_out_ready)
   );

   adma_mem_model mem (
      .CLK       (CLK),
      .RESET     (RESET),
      .ready_en  (mem_ready_en),
      .req       (mem_req),
      .req_valid (mem_req_valid),
      .req_ready (mem_req_ready),
      .rsp_valid (mem_rsp_valid),
      .rsp_data  (mem_rsp_data)
   );

   initial begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   // random stalls, fifo_in source and fifo_out sink, all on the falling edge
   initial begin
      void'($urandom(29));
      forever begin
         @(negedge CLK);
         mem_ready_en   = (($urandom % 4) != 0);
         fifo_out_ready = sink_throttle ? (($urandom % 2) != 0) : 1'b1;
         fifo_in_valid  = (src_q.size() != 0);
         fifo_in_data   = fifo_in_valid ? src_q[0] : '0;
      end
   end

   always @(posedge CLK) begin
      if (!RESET) begin
         if (fifo_out_valid && fifo_out_ready) begin
            recv_q.push_back(fifo_out_data);
         end
         if (fifo_in_valid && fifo_in_ready) begin
            void'(src_q.pop_front());
         end
         if (done) begin
            done_cnt = done_cnt + 1;
         end
         if (irq) begin
            irq_cnt = irq_cnt + 1;
         end
         // error stays high until the next command, so only a rise is new
         if (error && !error_q) begin
            error_seen = 1'b1;
         end
         error_q = error;
      end
   end

   always @(posedge CLK) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles) begin
         $display("timeout: the run did not end within %0d cycles", timeout_cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      check_cnt = check_cnt + 1;
      if (got !== exp) begin
         $display("ERR %s got=0x%h exp=0x%h", name, got, exp);
         err_cnt = err_cnt + 1;
      end
   endtask

   function automatic adma_pkg::word_t desc_w0(input int unsigned len, input logic [1:0] act,
                                               input logic irq_f, input logic end_f,
                                               input logic valid_f);
      return {len[15:0], 10'b0, act[1], act[0], 1'b0, irq_f, end_f, valid_f};
   endfunction

   function automatic adma_pkg::word_t data_word(input int unsigned tag, input int unsigned i);
      return adma_pkg::word_t'(32'hC0DE_0000 ^ (tag << 12) ^ i);
   endfunction

   task automatic put_desc(input int unsigned addr, input adma_pkg::word_t w0,
                           input adma_pkg::word_t w1);
      mem.mem_array[addr] = w0;
      mem.mem_array[addr + 1] = w1;
   endtask

   // source words in memory, also queued as the expected stream
   task automatic fill_source(input int unsigned tag, input int unsigned base, input int unsigned n);
      adma_pkg::word_t w;
      for (int unsigned i = 0; i < n; i++) begin
         w = data_word(tag, i);
         mem.mem_array[base + i] = w;
         exp_q.push_back(w);
      end
   endtask

   task automatic begin_test;
      @(negedge CLK);
      recv_q.delete();
      exp_q.delete();
      src_q.delete();
      done_cnt = 0;
      irq_cnt = 0;
      error_seen = 1'b0;
      test_cnt = test_cnt + 1;
      test_err_base = err_cnt;
   endtask

   task automatic finish_test(input string name);
      $display("test %0d %s finished with %0d errors", test_cnt, name, err_cnt - test_err_base);
   endtask

   task automatic issue_start(input int unsigned addr, input logic d);
      @(negedge CLK);
      start_valid = 1'b1;
      start_addr = addr;
      dir = d;
      @(negedge CLK);
      start_valid = 1'b0;
   endtask

   task automatic issue_cont(input logic d);
      @(negedge CLK);
      cont_valid = 1'b1;
      dir = d;
      @(negedge CLK);
      cont_valid = 1'b0;
   endtask

   // a few idle cycles after the end catch stray words or pulses
   task automatic wait_end;
      while ((done_cnt == 0) && !error_seen) begin
         @(posedge CLK);
      end
      repeat (8) @(posedge CLK);
      @(negedge CLK);
   endtask

   task automatic compare_stream;
      check_val("fifo_out_count", recv_q.size(), exp_q.size());
      for (int i = 0; (i < recv_q.size()) && (i < exp_q.size()); i++) begin
         check_val($sformatf("fifo_out_data[%0d]", i), recv_q[i], exp_q[i]);
      end
   endtask

   task automatic test_reset_values;
      begin_test();
      check_val("busy", busy, 0);
      check_val("done", done, 0);
      check_val("irq", irq, 0);
      check_val("error", error, 0);
      check_val("mem_req_valid", mem_req_valid, 0);
      check_val("fifo_out_valid", fifo_out_valid, 0);
      check_val("fifo_in_ready", fifo_in_ready, 0);
      finish_test("reset_values");
   endtask

   task automatic test_mem_to_fifo;
      begin_test();
      sink_throttle = 1'b0;
      put_desc(16, desc_w0(8, code_tran, 1'b0, 1'b1, 1'b1), 32'h100);
      fill_source(1, 32'h100, 8);
      issue_start(16, 1'b1);
      wait_end();
      compare_stream();
      check_val("done_count", done_cnt, 1);
      check_val("error", error_seen, 0);
      check_val("irq_count", irq_cnt, 0);
      finish_test("mem_to_fifo");
   endtask

   task automatic test_fifo_to_mem;
      adma_pkg::word_t w;
      begin_test();
      sink_throttle = 1'b1;
      put_desc(32, desc_w0(6, code_tran, 1'b0, 1'b1, 1'b1), 32'h200);
      for (int unsigned i = 0; i < 6; i++) begin
         w = data_word(2, i);
         mem.mem_array[32'h200 + i] = '0;
         src_q.push_back(w);
         exp_q.push_back(w);
      end
      issue_start(32, 1'b0);
      wait_end();
      for (int unsigned i = 0; i < 6; i++) begin
         check_val($sformatf("mem[0x%0h]", 32'h200 + i), mem.mem_array[32'h200 + i], exp_q[i]);
      end
      check_val("fifo_in_left", src_q.size(), 0);
      check_val("fifo_out_count", recv_q.size(), 0);
      check_val("done_count", done_cnt, 1);
      check_val("error", error_seen, 0);
      finish_test("fifo_to_mem");
   endtask

   task automatic test_chain;
      begin_test();
      sink_throttle = 1'b0;
      put_desc(48, desc_w0(0, code_nop, 1'b1, 1'b0, 1'b1), 32'h0);
      put_desc(50, desc_w0(0, code_link, 1'b0, 1'b0, 1'b1), 32'd80);
      // invalid descriptor right after the link, reached only if the link is ignored
      put_desc(52, 32'h0, 32'h0);
      put_desc(80, desc_w0(4, code_tran, 1'b1, 1'b0, 1'b1), 32'h300);
      put_desc(82, desc_w0(3, code_tran, 1'b0, 1'b1, 1'b1), 32'h310);
      fill_source(3, 32'h300, 4);
      fill_source(4, 32'h310, 3);
      issue_start(48, 1'b1);
      wait_end();
      compare_stream();
      check_val("irq_count", irq_cnt, 2);
      check_val("done_count", done_cnt, 1);
      check_val("error", error_seen, 0);
      finish_test("chain");
   endtask

   task automatic test_continue;
      begin_test();
      sink_throttle = 1'b0;
      put_desc(96, desc_w0(2, code_tran, 1'b0, 1'b1, 1'b1), 32'h380);
      put_desc(98, desc_w0(3, code_tran, 1'b0, 1'b1, 1'b1), 32'h390);
      fill_source(5, 32'h380, 2);
      issue_start(96, 1'b1);
      wait_end();
      compare_stream();
      check_val("done_count", done_cnt, 1);
      // resume at the descriptor after the end one
      recv_q.delete();
      exp_q.delete();
      done_cnt = 0;
      fill_source(6, 32'h390, 3);
      issue_cont(1'b1);
      wait_end();
      compare_stream();
      check_val("done_count", done_cnt, 1);
      check_val("error", error_seen, 0);
      finish_test("continue");
   endtask

   task automatic test_invalid;
      begin_test();
      sink_throttle = 1'b0;
      put_desc(112, desc_w0(4, code_tran, 1'b0, 1'b1, 1'b0), 32'h3A0);
      issue_start(112, 1'b1);
      wait_end();
      check_val("error_seen", error_seen, 1);
      check_val("error", error, 1);
      check_val("busy", busy, 0);
      check_val("fifo_out_count", recv_q.size(), 0);
      check_val("done_count", done_cnt, 0);
      finish_test("invalid");
   endtask

   task automatic test_stop;
      begin_test();
      sink_throttle = 1'b1;
      put_desc(128, desc_w0(5, code_tran, 1'b0, 1'b0, 1'b1), 32'h3C0);
      put_desc(130, desc_w0(4, code_tran, 1'b0, 1'b1, 1'b1), 32'h3D0);
      fill_source(7, 32'h3C0, 5);
      // second transfer data, never expected
      for (int unsigned i = 0; i < 4; i++) begin
         mem.mem_array[32'h3D0 + i] = data_word(8, i);
      end
      stop_req = 1'b1;
      issue_start(128, 1'b1);
      wait_end();
      stop_req = 1'b0;
      compare_stream();
      check_val("done_count", done_cnt, 1);
      check_val("error", error_seen, 0);
      check_val("busy", busy, 0);
      finish_test("stop");
   endtask

   initial begin
      RESET = 1'b1;
      start_valid = 1'b0;
      start_addr = '0;
      cont_valid = 1'b0;
      dir = 1'b0;
      stop_req = 1'b0;
      fifo_in_data = '0;
      fifo_in_valid = 1'b0;
      fifo_out_ready = 1'b0;
      mem_ready_en = 1'b0;
      sink_throttle = 1'b0;
      done_cnt = 0;
      irq_cnt = 0;
      error_seen = 1'b0;
      error_q = 1'b0;
      err_cnt = 0;
      check_cnt = 0;
      test_cnt = 0;
      test_err_base = 0;
      cycle_cnt = 0;
      repeat (10) @(posedge CLK);
      @(negedge CLK);
      RESET = 1'b0;
      test_reset_values();
      test_mem_to_fifo();
      test_fifo_to_mem();
      test_chain();
      test_continue();
      test_invalid();
      test_stop();
      $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/adma_mem_model.sv ====
// behavioral word memory with random request stalls and in-order delayed read data
`timescale 1ns/1ps
`default_nettype none

module adma_mem_model (
   input  logic               CLK,
   input  logic               RESET,
   input  logic               ready_en,
   input  adma_pkg::mem_req_t req,
   input  logic               req_valid,
   output logic               req_ready,
   output logic               rsp_valid,
   output adma_pkg::word_t    rsp_data
);

   adma_pkg::word_t mem_array [1024];
   adma_pkg::word_t rsp_word_q [$];
   int unsigned     rsp_due_q [$];
   int unsigned     cyc;
   int unsigned     last_due;

   // stall pattern comes from the testbench random stream
   assign req_ready = ready_en && !RESET;

   initial begin
      cyc = 0;
      last_due = 0;
      for (int i = 0; i < 1024; i++) begin
         mem_array[i] = 32'h5A00_0000 ^ (adma_pkg::word_t'(i) * 32'h9E37_79B1);
      end
   end

   always @(posedge CLK) begin
      int unsigned due;
      cyc = cyc + 1;
      rsp_valid <= 1'b0;
      if (RESET) begin
         rsp_word_q.delete();
         rsp_due_q.delete();
         last_due = cyc;
      end else begin
         if ((rsp_due_q.size() != 0) && (rsp_due_q[0] <= cyc)) begin
            rsp_valid <= 1'b1;
            rsp_data  <= rsp_word_q.pop_front();
            void'(rsp_due_q.pop_front());
         end
         if (req_valid && req_ready) begin
            if (req.write) begin
               mem_array[req.addr[9:0]] = req.wdata;
            end else begin
               // 1 to 3 cycles from the low address bits, never overtaking
               due = cyc + 1 + (req.addr % 3);
               if (due <= last_due) begin
                  due = last_due + 1;
               end
               last_due = due;
               rsp_word_q.push_back(mem_array[req.addr[9:0]]);
               rsp_due_q.push_back(due);
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/adma_top.sv ====
// adma top level that joins the control FSM, descriptor fetch and data transfer
`timescale 1ns/1ps
`default_nettype none

module adma_top #(
   parameter int unsigned MAX_OUTSTANDING = 2
) (
   input  logic               CLK,
   input  logic               RESET,
   input  logic               start_valid,
   input  adma_pkg::addr_t    start_addr,
   input  logic               cont_valid,
   input  logic               dir,
   input  logic               stop_req,
   output logic               busy,
   output logic               done,
   output logic               irq,
   output logic               error,
   output adma_pkg::mem_req_t mem_req,
   output logic               mem_req_valid,
   input  logic               mem_req_ready,
   input  logic               mem_rsp_valid,
   input  adma_pkg::word_t    mem_rsp_data,
   input  adma_pkg::word_t    fifo_in_data,
   input  logic               fifo_in_valid,
   output logic               fifo_in_ready,
   output adma_pkg::word_t    fifo_out_data,
   output logic               fifo_out_valid,
   input  logic               fifo_out_ready
);

   logic               fetch_start;
   adma_pkg::addr_t    fetch_addr;
   adma_pkg::mem_req_t fetch_req;
   logic               fetch_req_valid;
   logic               fetch_req_ready;
   logic               desc_ready;
   adma_pkg::desc_t    desc;
   logic               xfer_start;
   logic               xfer_dir;
   adma_pkg::mem_req_t xfer_req;
   logic               xfer_req_valid;
   logic               xfer_req_ready;
   logic               xfer_done;

   adma_control u_control (
      .CLK             (CLK),
      .RESET           (RESET),
      .start_valid     (start_valid),
      .start_addr      (start_addr),
      .cont_valid      (cont_valid),
      .dir             (dir),
      .stop_req        (stop_req),
      .busy            (busy),
      .done            (done),
      .irq             (irq),
      .error           (error),
      .mem_req         (mem_req),
      .mem_req_valid   (mem_req_valid),
      .mem_req_ready   (mem_req_ready),
      .fetch_start     (fetch_start),
      .fetch_addr      (fetch_addr),
      .fetch_req       (fetch_req),
      .fetch_req_valid (fetch_req_valid),
      .fetch_req_ready (fetch_req_ready),
      .desc_ready      (desc_ready),
      .desc            (desc),
      .xfer_start      (xfer_start),
      .xfer_dir        (xfer_dir),
      .xfer_req        (xfer_req),
      .xfer_req_valid  (xfer_req_valid),
      .xfer_req_ready  (xfer_req_ready),
      .xfer_done       (xfer_done)
   );

   // memory responses go to both datapaths
   descriptor_fetch u_fetch (
      .CLK           (CLK),
      .RESET         (RESET),
      .fetch_start   (fetch_start),
      .fetch_addr    (fetch_addr),
      .mem_req       (fetch_req),
      .mem_req_valid (fetch_req_valid),
      .mem_req_ready (fetch_req_ready),
      .mem_rsp_valid (mem_rsp_valid),
      .mem_rsp_data  (mem_rsp_data),
      .desc_ready    (desc_ready),
      .desc          (desc)
   );

   data_transfer #(
      .MAX_OUTSTANDING (MAX_OUTSTANDING)
   ) u_transfer (
      .CLK            (CLK),
      .RESET          (RESET),
      .xfer_start     (xfer_start),
      .dir            (xfer_dir),
      .xfer_addr      (desc.address),
      .xfer_len       (desc.length),
      .mem_req        (xfer_req),
      .mem_req_valid  (xfer_req_valid),
      .mem_req_ready  (xfer_req_ready),
      .mem_rsp_valid  (mem_rsp_valid),
      .mem_rsp_data   (mem_rsp_data),
      .fifo_in_data   (fifo_in_data),
      .fifo_in_valid  (fifo_in_valid),
      .fifo_in_ready  (fifo_in_ready),
      .fifo_out_data  (fifo_out_data),
      .fifo_out_valid (fifo_out_valid),
      .fifo_out_ready (fifo_out_ready),
      .xfer_done      (xfer_done)
   );

endmodule

`default_nettype wire

// ==== src/data_transfer.sv ====
// data transfer unit that moves a run of words between memory and the FIFO streams
`timescale 1ns/1ps
`default_nettype none

module data_transfer #(
   parameter int unsigned MAX_OUTSTANDING = 2
) (
   input  logic               CLK,
   input  logic               RESET,
   input  logic               xfer_start,
   input  logic               dir,
   input  adma_pkg::addr_t    xfer_addr,
   input  adma_pkg::len_t     xfer_len,
   output adma_pkg::mem_req_t mem_req,
   output logic               mem_req_valid,
   input  logic               mem_req_ready,
   input  logic               mem_rsp_valid,
   input  adma_pkg::word_t    mem_rsp_data,
   input  adma_pkg::word_t    fifo_in_data,
   input  logic               fifo_in_valid,
   output logic               fifo_in_ready,
   output adma_pkg::word_t    fifo_out_data,
   output logic               fifo_out_valid,
   input  logic               fifo_out_ready,
   output logic               xfer_done
);

   localparam int unsigned ptr_w = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
   localparam logic [ptr_w-1:0] ptr_last = ptr_w'(MAX_OUTSTANDING - 1);
   localparam adma_pkg::len_t max_pend = adma_pkg::len_t'(MAX_OUTSTANDING);

   logic             active;
   logic             dir_q;
   adma_pkg::addr_t  base_addr;
   adma_pkg::len_t   len_q;
   adma_pkg::len_t   req_cnt;
   adma_pkg::len_t   rsp_cnt;
   adma_pkg::len_t   out_cnt;
   adma_pkg::word_t  rd_buf [MAX_OUTSTANDING];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic             more_req;
   logic             rd_issue;
   logic             wr_issue;
   logic             req_take;
   logic             pop;
   logic             last_pop;
   logic             last_write;

   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
      return (p == ptr_last) ? '0 : p + 1'b1;
   endfunction

   assign more_req = active && (req_cnt != len_q);
   // reads in flight plus buffered words stay within the buffer
   assign rd_issue = more_req && dir_q && ((req_cnt - out_cnt) < max_pend);
   assign wr_issue = more_req && !dir_q && fifo_in_valid;

   assign mem_req_valid = rd_issue || wr_issue;
   assign mem_req.addr  = base_addr + adma_pkg::addr_t'(req_cnt);
   assign mem_req.write = !dir_q;
   assign mem_req.wdata = fifo_in_data;
   assign req_take      = mem_req_valid && mem_req_ready;

   // fifo_in word is consumed together with its write request
   assign fifo_in_ready = more_req && !dir_q && mem_req_ready;

   assign fifo_out_valid = active && dir_q && (rsp_cnt != out_cnt);
   assign fifo_out_data  = rd_buf[rd_ptr];
   assign pop            = fifo_out_valid && fifo_out_ready;

   assign last_pop   = pop && ((out_cnt + adma_pkg::len_t'(1)) == len_q);
   assign last_write = req_take && !dir_q && ((req_cnt + adma_pkg::len_t'(1)) == len_q);

   always_ff @(posedge CLK) begin
      if (RESET) begin
         active    <= 1'b0;
         dir_q     <= 1'b0;
         xfer_done <= 1'b0;
         req_cnt   <= '0;
         rsp_cnt   <= '0;
         out_cnt   <= '0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
      end else begin
         xfer_done <= 1'b0;
         if (xfer_start) begin
            // zero length finishes right away
            active    <= (xfer_len != '0);
            xfer_done <= (xfer_len == '0);
            dir_q     <= dir;
            req_cnt   <= '0;
            rsp_cnt   <= '0;
            out_cnt   <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
         end else if (active) begin
            if (req_take) begin
               req_cnt <= req_cnt + adma_pkg::len_t'(1);
            end
            if (dir_q && mem_rsp_valid) begin
               rsp_cnt <= rsp_cnt + adma_pkg::len_t'(1);
               wr_ptr  <= ptr_inc(wr_ptr);
            end
            if (pop) begin
               out_cnt <= out_cnt + adma_pkg::len_t'(1);
               rd_ptr  <= ptr_inc(rd_ptr);
            end
            if (last_pop || last_write) begin
               active    <= 1'b0;
               xfer_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (xfer_start) begin
         base_addr <= xfer_addr;
         len_q     <= xfer_len;
      end
      if (active && dir_q && mem_rsp_valid) begin
         rd_buf[wr_ptr] <= mem_rsp_data;
      end
   end

   a_reads_in_flight: assert property (@(posedge CLK) disable iff (RESET)
      (active && dir_q) |-> ((req_cnt - rsp_cnt) <= max_pend));

endmodule

`default_nettype wire

// ==== src/descriptor_fetch.sv ====
// descriptor fetch unit that reads two descriptor words and presents the decoded descriptor
`timescale 1ns/1ps
`default_nettype none

module descriptor_fetch (
   input  logic               CLK,
   input  logic               RESET,
   input  logic               fetch_start,
   input  adma_pkg::addr_t    fetch_addr,
   output adma_pkg::mem_req_t mem_req,
   output logic               mem_req_valid,
   input  logic               mem_req_ready,
   input  logic               mem_rsp_valid,
   input  adma_pkg::word_t    mem_rsp_data,
   output logic               desc_ready,
   output adma_pkg::desc_t    desc
);

   localparam logic [1:0] last_word = 2'(adma_pkg::desc_words - 1);

   logic            active;
   logic [1:0]      req_cnt;
   logic [1:0]      rsp_cnt;
   adma_pkg::addr_t base_addr;
   adma_pkg::word_t word0;

   // read-only requests at consecutive addresses
   assign mem_req_valid = active && (req_cnt <= last_word);
   assign mem_req.addr  = base_addr + adma_pkg::addr_t'(req_cnt);
   assign mem_req.write = 1'b0;
   assign mem_req.wdata = '0;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         active     <= 1'b0;
         req_cnt    <= '0;
         rsp_cnt    <= '0;
         desc_ready <= 1'b0;
      end else begin
         desc_ready <= 1'b0;
         if (fetch_start) begin
            active  <= 1'b1;
            req_cnt <= '0;
            rsp_cnt <= '0;
         end else if (active) begin
            if (mem_req_valid && mem_req_ready) begin
               req_cnt <= req_cnt + 2'd1;
            end
            // responses only count while this unit has reads out
            if (mem_rsp_valid) begin
               rsp_cnt <= rsp_cnt + 2'd1;
               if (rsp_cnt == last_word) begin
                  active     <= 1'b0;
                  desc_ready <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (fetch_start) begin
         base_addr <= fetch_addr;
      end
      if (active && mem_rsp_valid) begin
         if (rsp_cnt == last_word) begin
            desc <= adma_pkg::desc_decode(word0, mem_rsp_data);
         end else begin
            word0 <= mem_rsp_data;
         end
      end
   end

   a_rsp_has_read: assert property (@(posedge CLK) disable iff (RESET)
      (active && mem_rsp_valid) |-> (req_cnt != rsp_cnt));

endmodule

`default_nettype wire

// ==== src/adma_control.sv ====
// adma control FSM that walks the descriptor chain and owns the memory port
`timescale 1ns/1ps
`default_nettype none

module adma_control (
   input  logic                CLK,
   input  logic                RESET,
   input  logic                start_valid,
   input  adma_pkg::addr_t     start_addr,
   input  logic                cont_valid,
   input  logic                dir,
   input  logic                stop_req,
   output logic                busy,
   output logic                done,
   output logic                irq,
   output logic                error,
   output adma_pkg::mem_req_t  mem_req,
   output logic                mem_req_valid,
   input  logic                mem_req_ready,
   output logic                fetch_start,
   output adma_pkg::addr_t     fetch_addr,
   input  adma_pkg::mem_req_t  fetch_req,
   input  logic                fetch_req_valid,
   output logic                fetch_req_ready,
   input  logic                desc_ready,
   input  adma_pkg::desc_t     desc,
   output logic                xfer_start,
   output logic                xfer_dir,
   input  adma_pkg::mem_req_t  xfer_req,
   input  logic                xfer_req_valid,
   output logic                xfer_req_ready,
   input  logic                xfer_done
);

   adma_pkg::adma_state_e state;
   adma_pkg::adma_state_e state_nxt;
   adma_pkg::addr_t       next_ptr;
   logic                  cmd_accept;
   logic                  was_busy;
   logic                  desc_end;

   assign cmd_accept = (state == adma_pkg::st_stop) && (start_valid || cont_valid);
   assign busy       = (state != adma_pkg::st_stop);
   assign fetch_addr = next_ptr;

   // chain ends on the end attribute or a pending stop request
   assign desc_end = desc.last || stop_req;

   always_comb begin
      state_nxt = state;
      case (state)
         adma_pkg::st_stop: begin
            if (cmd_accept) begin
               state_nxt = adma_pkg::st_fds;
            end
         end
         adma_pkg::st_fds: begin
            if (desc_ready) begin
               state_nxt = desc.valid ? adma_pkg::st_cadr : adma_pkg::st_stop;
            end
         end
         adma_pkg::st_cadr: begin
            if (desc.action == adma_pkg::act_tran) begin
               state_nxt = adma_pkg::st_tfr;
            end else if (desc_end) begin
               state_nxt = adma_pkg::st_stop;
            end else begin
               state_nxt = adma_pkg::st_fds;
            end
         end
         adma_pkg::st_tfr: begin
            if (xfer_done) begin
               state_nxt = desc_end ? adma_pkg::st_stop : adma_pkg::st_fds;
            end
         end
         default: begin
            state_nxt = adma_pkg::st_stop;
         end
      endcase
   end

   always_ff @(posedge CLK) begin
      if (RESET) begin
         state       <= adma_pkg::st_stop;
         next_ptr    <= '0;
         xfer_dir    <= 1'b0;
         fetch_start <= 1'b0;
         xfer_start  <= 1'b0;
         was_busy    <= 1'b0;
         done        <= 1'b0;
         irq         <= 1'b0;
         error       <= 1'b0;
      end else begin
         state       <= state_nxt;
         fetch_start <= (state_nxt == adma_pkg::st_fds) && (state != adma_pkg::st_fds);
         xfer_start  <= (state == adma_pkg::st_cadr) && (state_nxt == adma_pkg::st_tfr);
         was_busy    <= busy;
         // one cycle after the return to st_stop, unless the chain failed
         done        <= (state == adma_pkg::st_stop) && was_busy && !error;
         // irq once the descriptor is finished
         irq <= desc.irq &&
                (((state == adma_pkg::st_cadr) && (desc.action != adma_pkg::act_tran)) ||
                 ((state == adma_pkg::st_tfr) && xfer_done));
         if (cmd_accept) begin
            error    <= 1'b0;
            xfer_dir <= dir;
            if (start_valid) begin
               next_ptr <= start_addr;
            end
         end
         if ((state == adma_pkg::st_fds) && desc_ready && !desc.valid) begin
            error <= 1'b1;
         end
         if (state == adma_pkg::st_cadr) begin
            if (desc.action == adma_pkg::act_link) begin
               next_ptr <= desc.address;
            end else begin
               next_ptr <= next_ptr + adma_pkg::addr_t'(adma_pkg::desc_words);
            end
         end
      end
   end

   // memory port goes to whichever datapath owns the state
   assign mem_req         = (state == adma_pkg::st_tfr) ? xfer_req : fetch_req;
   assign mem_req_valid   = ((state == adma_pkg::st_fds) && fetch_req_valid) ||
                            ((state == adma_pkg::st_tfr) && xfer_req_valid);
   assign fetch_req_ready = (state == adma_pkg::st_fds) && mem_req_ready;
   assign xfer_req_ready  = (state == adma_pkg::st_tfr) && mem_req_ready;

   a_single_owner: assert property (@(posedge CLK) disable iff (RESET)
      !(fetch_req_valid && xfer_req_valid));

   a_done_not_error: assert property (@(posedge CLK) disable iff (RESET)
      !(done && error));

endmodule

`default_nettype wire

// ==== src/adma_pkg.sv ====
// adma package holding the shared widths, descriptor layout, state types and memory request
`default_nettype none

package adma_pkg;

   // word address, data word and transfer length
   typedef logic [31:0] addr_t;
   typedef logic [31:0] word_t;
   typedef logic [15:0] len_t;

   // descriptor size in memory words
   localparam int unsigned desc_words = 2;

   // decoded from {act2, act1}
   typedef enum logic [1:0] {
      act_nop  = 2'b00,
      act_rsv  = 2'b01,
      act_tran = 2'b10,
      act_link = 2'b11
   } action_e;

   typedef struct packed {
      addr_t   address;
      len_t    length;
      action_e action;
      logic    irq;
      logic    last;
      logic    valid;
   } desc_t;

   typedef struct packed {
      addr_t addr;
      logic  write;
      word_t wdata;
   } mem_req_t;

   typedef enum logic [1:0] {
      st_stop = 2'b00,
      st_fds  = 2'b01,
      st_cadr = 2'b10,
      st_tfr  = 2'b11
   } adma_state_e;

   // word 0 carries length and attribute bits, word 1 the address
   function automatic desc_t desc_decode(input word_t w0, input word_t w1);
      desc_t d;
      d.address = w1;
      d.length  = w0[31:16];
      d.action  = action_e'(w0[5:4]);
      d.irq     = w0[2];
      d.last    = w0[1];
      d.valid   = w0[0];
      return d;
   endfunction

endpackage

`default_nettype wire
